/* compile.f */
verilog/avmm_pkg.sv
verilog/avmm_mem_if.sv
verilog/avmm_connect_slave_clk.sv
verilog/avmm_beat_counter.sv
verilog/avmm_copy_fsm.sv
verilog/avmm_line_buffer.sv
verilog/avmm_sram.sv
verilog/avmm_copy_top.sv
dv/tb_avmm_copy.sv

/* dv/tb_avmm_copy.sv */
`timescale 1ns/1ps

// Testbench for the Avalon copy engine, checked against a word model of the memory
module tb_avmm_copy;
    import avmm_pkg::*;

    localparam int BURST_LEN    = 4;
    localparam int READ_LATENCY = 2;
    localparam int MEM_WORDS    = 2**ADDR_W;
    localparam int NUM_RAND     = 3;
    localparam int NUM_SWEEPS   = 8;

    logic               clk;
    logic               rst_n;
    logic               start;
    logic [ADDR_W-1:0]  src_addr;
    logic [ADDR_W-1:0]  dst_addr;
    logic [7:0]         num_bursts;
    logic               busy;
    logic               done;
    logic               host_read;
    logic               host_write;
    logic [ADDR_W-1:0]  host_address;
    logic [DATA_W-1:0]  host_writedata;
    logic [DATA_W-1:0]  host_readdata;
    logic               host_readdatavalid;

    logic [DATA_W-1:0]  model [MEM_WORDS];
    logic [DATA_W-1:0]  exp_rdata;
    logic [ADDR_W-1:0]  rand_src [NUM_RAND];
    logic [ADDR_W-1:0]  rand_dst [NUM_RAND];
    int                 rand_len [NUM_RAND];
    int                 seed;
    int                 errors = 0;
    int                 start_count = 0;
    int                 done_count = 0;
    int                 limit_cycles = 0;
    int                 total_bursts;

    avmm_copy_top #(.BURST_LEN(BURST_LEN), .READ_LATENCY(READ_LATENCY)) dut_i (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Host read data is due one cycle after the read, so the expected word follows it
    always @(posedge clk)
    begin
        if (host_read)
            exp_rdata <= model[host_address];
        if (done)
            done_count <= done_count + 1;
    end

    // Counts one wrong value and prints the signal with both values
    task automatic report_mismatch(input string name, input logic [DATA_W-1:0] exp_val,
                                   input logic [DATA_W-1:0] got_val);
        errors++;
        $display("MISMATCH t=%0t %s exp=%0h got=%0h", $time, name, exp_val, got_val);
    endtask

    // While reset is low the engine must be idle and silent
    reset_busy: assert property (@(posedge clk) !rst_n |-> !busy)
        else report_mismatch("busy", 0, $sampled(busy));
    reset_done: assert property (@(posedge clk) !rst_n |-> !done)
        else report_mismatch("done", 0, $sampled(done));

    host_valid: assert property (@(posedge clk) disable iff (!rst_n)
        host_read |=> host_readdatavalid)
        else report_mismatch("host_readdatavalid", 1, $sampled(host_readdatavalid));
    host_data: assert property (@(posedge clk) disable iff (!rst_n)
        host_readdatavalid |-> host_readdata == exp_rdata)
        else report_mismatch("host_readdata", $sampled(exp_rdata), $sampled(host_readdata));

    // Start while idle raises busy next cycle, and done ends busy in its own cycle
    start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        start && !busy |=> busy)
        else report_mismatch("busy", 1, $sampled(busy));
    done_idle: assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
        else report_mismatch("busy", 0, $sampled(busy));
    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else report_mismatch("done", 0, $sampled(done));
    busy_end: assert property (@(posedge clk) disable iff (!rst_n) $fell(busy) |-> done)
        else report_mismatch("done", 1, $sampled(done));

    task automatic host_write_word(input logic [ADDR_W-1:0] addr,
                                   input logic [DATA_W-1:0] data);
        host_write     <= 1'b1;
        host_address   <= addr;
        host_writedata <= data;
        model[addr] = data;
        @(posedge clk);
        host_write <= 1'b0;
    endtask

    task automatic host_read_word(input logic [ADDR_W-1:0] addr);
        host_read    <= 1'b1;
        host_address <= addr;
        @(posedge clk);
        host_read <= 1'b0;
    endtask

    // Reads every word back, so untouched words are covered as well as the copy
    task automatic sweep_memory;
        for (int a = 0; a < MEM_WORDS; a++)
            host_read_word(ADDR_W'(a));
        repeat (2) @(posedge clk);
    endtask

    task automatic pulse_start(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                               input int bursts);
        src_addr   <= src;
        dst_addr   <= dst;
        num_bursts <= 8'(bursts);
        start      <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic run_copy(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                            input int bursts, input bit extra_start);
        logic [ADDR_W-1:0] s;
        logic [ADDR_W-1:0] d;
        pulse_start(src, dst, bursts);
        start_count++;
        if (extra_start)
        begin
            // Reversed regions would damage the source if this request were taken
            repeat (3) @(posedge clk);
            pulse_start(dst, src, 1);
        end
        do @(posedge clk); while (!done);
        // The destination takes the source words as they stood before the copy
        for (int i = 0; i < bursts * BURST_LEN; i++)
        begin
            s = src + ADDR_W'(i);
            d = dst + ADDR_W'(i);
            model[d] = model[s];
        end
        @(posedge clk);
        done_count_check: assert (done_count == start_count)
            else report_mismatch("done_count", start_count, done_count);
    endtask

    initial
    begin
        seed           = 23;
        rst_n          = 1'b0;
        start          = 1'b0;
        src_addr       = '0;
        dst_addr       = '0;
        num_bursts     = '0;
        host_read      = 1'b0;
        host_write     = 1'b0;
        host_address   = '0;
        host_writedata = '0;

        // Random copies read from the lower half and write to the upper half
        total_bursts = 10;
        for (int k = 0; k < NUM_RAND; k++)
        begin
            rand_len[k] = 1 + ({$random(seed)} % 6);
            rand_src[k] = ADDR_W'({$random(seed)} % 480);
            rand_dst[k] = ADDR_W'(512 + ({$random(seed)} % 480));
            total_bursts += rand_len[k];
        end
        limit_cycles = total_bursts * 40 + NUM_SWEEPS * (MEM_WORDS + 8) + 2000;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Fill the whole memory through the host port, then read it back
        for (int a = 0; a < MEM_WORDS; a++)
            host_write_word(ADDR_W'(a), $random(seed) ^ DATA_W'(a));
        sweep_memory();

        run_copy(10'd100, 10'd600, 1, 1'b0);
        sweep_memory();

        for (int k = 0; k < NUM_RAND; k++)
        begin
            run_copy(rand_src[k], rand_dst[k], rand_len[k], 1'b0);
            sweep_memory();
        end

        run_copy(10'd200, 10'd300, 2, 1'b1);
        sweep_memory();

        // Abort a copy partway through, then put the damaged region back
        pulse_start(10'd32, 10'd700, 4);
        repeat (8) @(posedge clk);
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int a = 700; a < 716; a++)
            host_write_word(ADDR_W'(a), model[a]);
        run_copy(10'd48, 10'd800, 3, 1'b0);
        sweep_memory();

        $display("Closing: %0d errors, %0d starts, %0d done pulses",
                 errors, start_count, done_count);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    // Watchdog sized from the copies and the full memory sweeps
    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("Closing: %0d errors, %0d starts, %0d done pulses",
                 errors, start_count, done_count);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the copy engine testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_avmm_copy \
    -f compile.f \
    -o sim_tb_avmm_copy

./obj_dir/sim_tb_avmm_copy | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

/* verilog/avmm_beat_counter.sv */
`timescale 1ns/1ps

// Beat position inside a burst and burst position inside one copy
module avmm_beat_counter
#(
    parameter int BURST_LEN = 4
)
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          clear,
    input  logic                          beat_inc,
    input  logic                          burst_inc,
    input  logic [7:0]                    num_bursts,
    output logic [$clog2(BURST_LEN)-1:0]  beat_idx,
    output logic [7:0]                    burst_idx,
    output logic                          last_beat,
    output logic                          last_burst
);

    localparam int IDX_W = $clog2(BURST_LEN);

    // Burst count captured at start so the copy length cannot shift mid-copy
    logic [7:0] nb_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            beat_idx  <= '0;
            burst_idx <= '0;
            nb_q      <= '0;
        end
        else if (clear)
        begin
            beat_idx  <= '0;
            burst_idx <= '0;
            nb_q      <= num_bursts;
        end
        else
        begin
            // The beat index wraps so read fill and write replay share it
            if (beat_inc)
            begin
                beat_idx <= last_beat ? '0 : beat_idx + 1'b1;
            end
            if (burst_inc)
            begin
                burst_idx <= burst_idx + 8'd1;
            end
        end
    end

    assign last_beat  = beat_idx == IDX_W'(BURST_LEN - 1);
    assign last_burst = burst_idx == nb_q - 8'd1;

endmodule

/* verilog/avmm_connect_slave_clk.sv */
`timescale 1ns/1ps

// Joins the engine link to the memory link with one command register stage
// Clock and reset come from the memory side and are handed to the engine side
module avmm_connect_slave_clk
(
    avmm_mem_if.to_master_clk mem_slave,
    avmm_mem_if.to_slave_clk  mem_master
);
    import avmm_pkg::*;

    logic                cmd_read;
    logic                cmd_write;
    logic [ADDR_W-1:0]   cmd_address;
    logic [BURST_W-1:0]  cmd_burstcount;
    logic [DATA_W-1:0]   cmd_writedata;
    logic                cmd_full;
    logic                take;

    // The engine runs on the memory clock and reset
    assign mem_master.clk   = mem_slave.clk;
    assign mem_master.rst_n = mem_slave.rst_n;

    assign cmd_full = cmd_read | cmd_write;

    // Stall the engine only when the register holds a beat the memory refuses
    // An empty register or one being drained this cycle can always take a new beat
    assign mem_master.waitrequest = cmd_full & mem_slave.waitrequest;
    assign take = (mem_master.read | mem_master.write) & ~mem_master.waitrequest;

    always_ff @(posedge mem_slave.clk or negedge mem_slave.rst_n)
    begin
        if (!mem_slave.rst_n)
        begin
            cmd_read  <= 1'b0;
            cmd_write <= 1'b0;
        end
        else if (take)
        begin
            cmd_read  <= mem_master.read;
            cmd_write <= mem_master.write;
        end
        else if (!mem_slave.waitrequest)
        begin
            // Memory took the held beat and nothing new arrived
            cmd_read  <= 1'b0;
            cmd_write <= 1'b0;
        end
    end

    always_ff @(posedge mem_slave.clk)
    begin
        if (take)
        begin
            cmd_address    <= mem_master.address;
            cmd_burstcount <= mem_master.burstcount;
            cmd_writedata  <= mem_master.writedata;
        end
    end

    // The held beat stays on the memory link until it is accepted
    assign mem_slave.read       = cmd_read;
    assign mem_slave.write      = cmd_write;
    assign mem_slave.address    = cmd_address;
    assign mem_slave.burstcount = cmd_burstcount;
    assign mem_slave.writedata  = cmd_writedata;

    // Read responses need no buffering
    assign mem_master.readdata      = mem_slave.readdata;
    assign mem_master.readdatavalid = mem_slave.readdatavalid;

endmodule

/* verilog/avmm_copy_fsm.sv */
`timescale 1ns/1ps

// Copy sequencer that reads one burst, buffers it, writes it back and repeats
module avmm_copy_fsm
#(
    parameter int BURST_LEN = 4
)
(
    input  logic                         start,
    input  logic [avmm_pkg::ADDR_W-1:0]  src_addr,
    input  logic [avmm_pkg::ADDR_W-1:0]  dst_addr,
    output logic                         busy,
    output logic                         done,
    avmm_mem_if.to_master_clk            eng,
    output logic                         clear,
    output logic                         beat_inc,
    output logic                         burst_inc,
    input  logic                         last_beat,
    input  logic                         last_burst,
    input  logic [7:0]                   burst_idx,
    output logic                         buf_wr,
    input  logic [avmm_pkg::DATA_W-1:0]  buf_data
);
    import avmm_pkg::*;

    copy_state_t        state;
    copy_state_t        state_nx;
    logic [ADDR_W-1:0]  src_q;
    logic [ADDR_W-1:0]  dst_q;
    logic [ADDR_W-1:0]  offset;
    logic               accepted;

    // A command beat goes through whenever the link is not stalling
    assign accepted = ~eng.waitrequest;
    assign offset   = ADDR_W'(burst_idx * BURST_LEN);

    // A start is only taken while idle, which also resets the counters
    assign clear = (state == IDLE) & start;
    assign busy  = state != IDLE;

    // Address, burstcount and write data are held until the beat is accepted
    assign eng.read       = state == RD_REQ;
    assign eng.write      = state == WR_BEAT;
    assign eng.address    = (state == WR_BEAT) ? dst_q + offset : src_q + offset;
    assign eng.burstcount = BURST_W'(BURST_LEN);
    assign eng.writedata  = buf_data;

    assign buf_wr    = (state == RD_DATA) & eng.readdatavalid;
    assign beat_inc  = buf_wr | ((state == WR_BEAT) & accepted);
    assign burst_inc = (state == WR_BEAT) & accepted & last_beat & ~last_burst;

    always_comb
    begin
        state_nx = state;
        case (state)
            IDLE:    if (start) state_nx = RD_REQ;
            RD_REQ:  if (accepted) state_nx = RD_DATA;
            RD_DATA: if (eng.readdatavalid && last_beat) state_nx = WR_BEAT;
            WR_BEAT:
            begin
                if (accepted && last_beat)
                begin
                    state_nx = last_burst ? DONE : RD_REQ;
                end
            end
            // The bridge still holds the final beat until the memory takes it
            DONE:    if (accepted) state_nx = IDLE;
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge eng.clk or negedge eng.rst_n)
    begin
        if (!eng.rst_n)
        begin
            state <= IDLE;
            done  <= 1'b0;
        end
        else
        begin
            state <= state_nx;
            // Pulses together with the return to IDLE, so busy drops with it
            done  <= (state == DONE) & accepted;
        end
    end

    // Region bases are captured so the host may change its inputs mid-copy
    always_ff @(posedge eng.clk)
    begin
        if (clear)
        begin
            src_q <= src_addr;
            dst_q <= dst_addr;
        end
    end

endmodule

/* verilog/avmm_copy_top.sv */
`timescale 1ns/1ps

// Memory copy engine with its on-chip memory and a host access port
module avmm_copy_top
#(
    parameter int BURST_LEN    = 4,
    parameter int READ_LATENCY = 2
)
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic [avmm_pkg::ADDR_W-1:0]  src_addr,
    input  logic [avmm_pkg::ADDR_W-1:0]  dst_addr,
    input  logic [7:0]                   num_bursts,
    output logic                         busy,
    output logic                         done,
    input  logic                         host_read,
    input  logic                         host_write,
    input  logic [avmm_pkg::ADDR_W-1:0]  host_address,
    input  logic [avmm_pkg::DATA_W-1:0]  host_writedata,
    output logic [avmm_pkg::DATA_W-1:0]  host_readdata,
    output logic                         host_readdatavalid
);
    import avmm_pkg::*;

    localparam int IDX_W = $clog2(BURST_LEN);

    logic               clear;
    logic               beat_inc;
    logic               burst_inc;
    logic               last_beat;
    logic               last_burst;
    logic               buf_wr;
    logic [IDX_W-1:0]   beat_idx;
    logic [7:0]         burst_idx;
    logic [DATA_W-1:0]  buf_data;

    // Engine side link gets its clock from the bridge, memory side from here
    avmm_mem_if eng_if();
    avmm_mem_if mem_if();

    assign mem_if.clk   = clk;
    assign mem_if.rst_n = rst_n;

    avmm_copy_fsm #(.BURST_LEN(BURST_LEN)) fsm_i
    (
        .start(start), .src_addr(src_addr), .dst_addr(dst_addr),
        .busy(busy), .done(done), .eng(eng_if),
        .clear(clear), .beat_inc(beat_inc), .burst_inc(burst_inc),
        .last_beat(last_beat), .last_burst(last_burst), .burst_idx(burst_idx),
        .buf_wr(buf_wr), .buf_data(buf_data)
    );

    avmm_beat_counter #(.BURST_LEN(BURST_LEN)) cnt_i
    (
        .clk(clk), .rst_n(rst_n), .clear(clear),
        .beat_inc(beat_inc), .burst_inc(burst_inc), .num_bursts(num_bursts),
        .beat_idx(beat_idx), .burst_idx(burst_idx),
        .last_beat(last_beat), .last_burst(last_burst)
    );

    // Read fill and write replay both walk the buffer by the beat index
    avmm_line_buffer #(.BURST_LEN(BURST_LEN)) buf_i
    (
        .clk(clk), .rst_n(rst_n), .wr(buf_wr), .wr_idx(beat_idx),
        .wr_data(eng_if.readdata), .rd_idx(beat_idx), .rd_data(buf_data)
    );

    avmm_connect_slave_clk conn_i
    (
        .mem_slave(mem_if), .mem_master(eng_if)
    );

    avmm_sram #(.READ_LATENCY(READ_LATENCY)) sram_i
    (
        .mem(mem_if), .host_read(host_read), .host_write(host_write),
        .host_address(host_address), .host_writedata(host_writedata),
        .host_readdata(host_readdata), .host_readdatavalid(host_readdatavalid)
    );

endmodule

/* verilog/avmm_line_buffer.sv */
`timescale 1ns/1ps

// One burst worth of read data, replayed as write data
module avmm_line_buffer
#(
    parameter int BURST_LEN = 4
)
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr,
    input  logic [$clog2(BURST_LEN)-1:0]  wr_idx,
    input  logic [avmm_pkg::DATA_W-1:0]   wr_data,
    input  logic [$clog2(BURST_LEN)-1:0]  rd_idx,
    output logic [avmm_pkg::DATA_W-1:0]   rd_data
);
    import avmm_pkg::*;

    logic [DATA_W-1:0] line_q [BURST_LEN];

    // One register per beat of the burst, filled by the read beat index
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < BURST_LEN; i++)
            begin
                line_q[i] <= '0;
            end
        end
        else if (wr)
        begin
            line_q[wr_idx] <= wr_data;
        end
    end

    // Combinational read lets every write beat follow the previous one directly
    // The index only moves on an accepted beat, so data stays put during a stall
    assign rd_data = line_q[rd_idx];

endmodule

/* verilog/avmm_mem_if.sv */
`timescale 1ns/1ps

// Avalon memory-mapped link with burst support
interface avmm_mem_if;
    import avmm_pkg::*;

    // Clock and reset travel with the link so a bridge can hand them on
    logic                clk;
    logic                rst_n;

    // Command side, driven by the master
    logic [ADDR_W-1:0]   address;
    logic                read;
    logic                write;
    logic [BURST_W-1:0]  burstcount;
    logic [DATA_W-1:0]   writedata;

    // Response side, driven by the slave
    logic                waitrequest;
    logic [DATA_W-1:0]   readdata;
    logic                readdatavalid;

    // Master that takes its clock and reset from the link
    modport to_master_clk
    (
        input  clk,
        input  rst_n,
        output address,
        output read,
        output write,
        output burstcount,
        output writedata,
        input  waitrequest,
        input  readdata,
        input  readdatavalid
    );

    // Slave that runs on the clock already present on the link
    modport to_slave
    (
        input  clk,
        input  rst_n,
        input  address,
        input  read,
        input  write,
        input  burstcount,
        input  writedata,
        output waitrequest,
        output readdata,
        output readdatavalid
    );

    // Slave that also supplies clock and reset to the master behind it
    modport to_slave_clk
    (
        output clk,
        output rst_n,
        input  address,
        input  read,
        input  write,
        input  burstcount,
        input  writedata,
        output waitrequest,
        output readdata,
        output readdatavalid
    );

endinterface

/* verilog/avmm_pkg.sv */
// Shared widths and the copy state encoding for the Avalon copy engine
package avmm_pkg;

    // Word address width, which gives 1024 words of memory
    localparam int ADDR_W = 10;

    // Data word width
    localparam int DATA_W = 32;

    // Burstcount field width, enough for bursts of up to 8 beats
    localparam int BURST_W = 4;

    // States of the copy FSM
    // IDLE waits for start and RD_REQ issues one read burst
    // RD_DATA collects the returned beats into the line buffer
    // WR_BEAT streams the buffered beats out as one write burst
    // DONE waits for the memory to take the final write beat
    typedef enum logic [2:0]
    {
        IDLE,
        RD_REQ,
        RD_DATA,
        WR_BEAT,
        DONE
    } copy_state_t;

endpackage

/* verilog/avmm_sram.sv */
`timescale 1ns/1ps

// Word memory with an Avalon burst slave port and a host side port
module avmm_sram
#(
    parameter int READ_LATENCY = 2
)
(
    avmm_mem_if.to_slave                 mem,
    input  logic                         host_read,
    input  logic                         host_write,
    input  logic [avmm_pkg::ADDR_W-1:0]  host_address,
    input  logic [avmm_pkg::DATA_W-1:0]  host_writedata,
    output logic [avmm_pkg::DATA_W-1:0]  host_readdata,
    output logic                         host_readdatavalid
);
    import avmm_pkg::*;

    logic [DATA_W-1:0]        ram [2**ADDR_W];
    logic                     host_busy;
    logic                     rd_take;
    logic                     wr_take;
    logic                     rd_issue;
    logic [ADDR_W-1:0]        rd_issue_addr;
    logic [ADDR_W-1:0]        rd_addr;
    logic [BURST_W-1:0]       rd_left;
    logic [ADDR_W-1:0]        wr_beat_addr;
    logic [ADDR_W-1:0]        wr_addr;
    logic [BURST_W-1:0]       wr_left;
    logic [READ_LATENCY-1:0]  pipe_valid;
    logic [DATA_W-1:0]        pipe_data [READ_LATENCY];

    // Host traffic wins and holds off the burst port for that cycle
    assign host_busy       = host_read | host_write;
    assign mem.waitrequest = host_busy;
    assign rd_take         = mem.read & ~host_busy;
    assign wr_take         = mem.write & ~host_busy;

    // Beat zero of a read leaves with the command, later beats from the counter
    assign rd_issue      = rd_take | (rd_left != '0);
    assign rd_issue_addr = rd_take ? mem.address : rd_addr;

    // First write beat of a burst carries the address, the rest count up from it
    assign wr_beat_addr = (wr_left == '0) ? mem.address : wr_addr;

    always_ff @(posedge mem.clk or negedge mem.rst_n)
    begin
        if (!mem.rst_n)
        begin
            rd_left            <= '0;
            wr_left            <= '0;
            pipe_valid         <= '0;
            host_readdatavalid <= 1'b0;
        end
        else
        begin
            if (rd_take)
                rd_left <= mem.burstcount - 1'b1;
            else if (rd_left != '0)
                rd_left <= rd_left - 1'b1;
            if (wr_take)
                wr_left <= (wr_left == '0) ? mem.burstcount - 1'b1 : wr_left - 1'b1;
            pipe_valid[0] <= rd_issue;
            for (int i = 1; i < READ_LATENCY; i++)
                pipe_valid[i] <= pipe_valid[i-1];
            host_readdatavalid <= host_read;
        end
    end

    always_ff @(posedge mem.clk)
    begin
        if (rd_issue)
            rd_addr <= rd_issue_addr + 1'b1;
        if (wr_take)
            wr_addr <= wr_beat_addr + 1'b1;
        // Host and burst writes never collide since waitrequest blocks the burst
        if (host_write)
            ram[host_address] <= host_writedata;
        else if (wr_take)
            ram[wr_beat_addr] <= mem.writedata;
        // Several read beats can be in flight along this pipeline
        pipe_data[0] <= ram[rd_issue_addr];
        for (int i = 1; i < READ_LATENCY; i++)
            pipe_data[i] <= pipe_data[i-1];
        if (host_read)
            host_readdata <= ram[host_address];
    end

    assign mem.readdata      = pipe_data[READ_LATENCY-1];
    assign mem.readdatavalid = pipe_valid[READ_LATENCY-1];

endmodule
